//--- common/bpf_params.svh
`ifndef BPF_PARAMS_SVH
`define BPF_PARAMS_SVH

// Instruction memory holds 1024 instructions
`define BPF_CODE_ADDR_WIDTH 10

// Packet memory is byte addressed, 4 KiB window
`define BPF_BYTE_ADDR_WIDTH 12

`define BPF_SCRATCH_DEPTH 16 // M[] words

`endif

//--- common/bpf_pkg.sv
`include "bpf_params.svh"

package bpf_pkg;

    typedef logic [31:0]                           word_t;
    typedef logic [`BPF_CODE_ADDR_WIDTH-1:0]       code_addr_t;
    typedef logic [`BPF_BYTE_ADDR_WIDTH-1:0]       byte_addr_t;
    typedef logic [$clog2(`BPF_SCRATCH_DEPTH)-1:0] scratch_addr_t;

    // Classic BPF instruction word
    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;
        logic [7:0]  jf;
        word_t       k;
    } inst_t;

    typedef enum logic [2:0] {
        A_SEL_IMM, A_SEL_ABS, A_SEL_IND, A_SEL_MEM, A_SEL_LEN, A_SEL_ALU, A_SEL_X
    } a_sel_e;

    typedef enum logic [2:0] {
        X_SEL_IMM, X_SEL_MEM, X_SEL_LEN, X_SEL_MSH, X_SEL_A
    } x_sel_e;

    typedef enum logic [1:0] {PC_PLUS_1, PC_PLUS_JT, PC_PLUS_JF, PC_PLUS_K} pc_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_MUL, ALU_OR, ALU_AND, ALU_LSH, ALU_RSH, ALU_XOR, ALU_NEG
    } alu_op_e;

    typedef struct packed {
        logic eq;
        logic gt;
        logic ge;
        logic set; // A & B nonzero
    } alu_flags_t;

    typedef struct packed {
        a_sel_e  a_sel;
        logic    a_en;
        x_sel_e  x_sel;
        logic    x_en;
        pc_sel_e pc_sel;
        logic    pc_en;
        logic    pc_clr;
        logic    b_sel_x;        // B operand is X, else k
        alu_op_e alu_op;
        logic    alu_en;
        logic    alu_ack;
        logic    scratch_from_x;
        logic    scratch_wr_en;
        logic    addr_ind;       // Packet address X+k
    } dp_ctrl_t;

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEMWAIT, S_ALUWAIT, S_DONE
    } ctrl_state_e;

    // Opcodes, standard classic BPF encoding
    localparam logic [15:0] OP_SRC_X   = 16'h0008; // OR into ALU and jump opcodes
    localparam logic [15:0] OP_LD_IMM  = 16'h0000;
    localparam logic [15:0] OP_LD_ABS  = 16'h0020;
    localparam logic [15:0] OP_LD_IND  = 16'h0040;
    localparam logic [15:0] OP_LD_MEM  = 16'h0060;
    localparam logic [15:0] OP_LD_LEN  = 16'h0080;
    localparam logic [15:0] OP_LDX_IMM = 16'h0001;
    localparam logic [15:0] OP_LDX_MEM = 16'h0061;
    localparam logic [15:0] OP_LDX_LEN = 16'h0081;
    localparam logic [15:0] OP_LDX_MSH = 16'h00b1;
    localparam logic [15:0] OP_ST      = 16'h0002;
    localparam logic [15:0] OP_STX     = 16'h0003;
    localparam logic [15:0] OP_ALU_ADD = 16'h0004;
    localparam logic [15:0] OP_ALU_SUB = 16'h0014;
    localparam logic [15:0] OP_ALU_MUL = 16'h0024;
    localparam logic [15:0] OP_ALU_OR  = 16'h0044;
    localparam logic [15:0] OP_ALU_AND = 16'h0054;
    localparam logic [15:0] OP_ALU_LSH = 16'h0064;
    localparam logic [15:0] OP_ALU_RSH = 16'h0074;
    localparam logic [15:0] OP_ALU_NEG = 16'h0084;
    localparam logic [15:0] OP_ALU_XOR = 16'h00a4;
    localparam logic [15:0] OP_JA      = 16'h0005;
    localparam logic [15:0] OP_JEQ     = 16'h0015;
    localparam logic [15:0] OP_JGT     = 16'h0025;
    localparam logic [15:0] OP_JGE     = 16'h0035;
    localparam logic [15:0] OP_JSET    = 16'h0045;
    localparam logic [15:0] OP_RET_K   = 16'h0006;
    localparam logic [15:0] OP_RET_A   = 16'h0016;
    localparam logic [15:0] OP_TAX     = 16'h0007;
    localparam logic [15:0] OP_TXA     = 16'h0087;

endpackage

//--- datapath/scratch_mem.sv
`timescale 1ns/1ps
`include "bpf_params.svh"

module scratch_mem (
    input  logic                   clk,
    input  logic                   rst,
    input  bpf_pkg::scratch_addr_t addr,
    input  bpf_pkg::word_t         wr_data,
    input  logic                   wr_en,
    output bpf_pkg::word_t         rd_data
);
    import bpf_pkg::*;

    word_t mem [`BPF_SCRATCH_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= mem[addr];
        end
    end

endmodule

//--- datapath/bpf_alu.sv
`timescale 1ns/1ps

module bpf_alu (
    input  logic                clk,
    input  logic                rst,
    input  bpf_pkg::word_t      a,
    input  bpf_pkg::word_t      b,
    input  bpf_pkg::alu_op_e    op,
    input  logic                en,
    input  logic                ack,
    output bpf_pkg::word_t      result,
    output bpf_pkg::alu_flags_t flags,
    output logic                vld
);
    import bpf_pkg::*;

    word_t      res_d;
    alu_flags_t flags_d;
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // All results wrap at 32 bits
    always_comb begin
        case (op)
            ALU_ADD: res_d = a + b;
            ALU_SUB: res_d = a - b;
            ALU_MUL: res_d = a * b;
            ALU_OR:  res_d = a | b;
            ALU_AND: res_d = a & b;
            ALU_LSH: res_d = a << shamt;
            ALU_RSH: res_d = a >> shamt;
            ALU_XOR: res_d = a ^ b;
            ALU_NEG: res_d = -a;
            default: res_d = '0;
        endcase
    end

    // Unsigned compares for the conditional jumps
    assign flags_d.eq  = (a == b);
    assign flags_d.gt  = (a > b);
    assign flags_d.ge  = (a >= b);
    assign flags_d.set = |(a & b);

    always_ff @(posedge clk) begin
        if (en) begin
            result <= res_d;
            flags  <= flags_d;
        end
    end

    // vld stays up until the controller acks
    always_ff @(posedge clk) begin
        if (rst) begin
            vld <= 1'b0;
        end else if (en) begin
            vld <= 1'b1;
        end else if (ack) begin
            vld <= 1'b0;
        end
    end

endmodule

//--- datapath/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic                clk,
    input  logic                rst,
    input  bpf_pkg::dp_ctrl_t   ctrl,
    input  bpf_pkg::word_t      k,
    input  bpf_pkg::word_t      pkt_len,
    input  bpf_pkg::word_t      pkt_data,
    output bpf_pkg::code_addr_t pc,
    output bpf_pkg::byte_addr_t pkt_addr,
    output bpf_pkg::word_t      acc,
    output bpf_pkg::alu_flags_t flags,
    output logic                alu_vld
);
    import bpf_pkg::*;

    word_t      a_q;
    word_t      x_q;
    code_addr_t pc_q;

    word_t      alu_b;
    word_t      alu_result;
    word_t      scratch_rd;
    word_t      scratch_wr;
    word_t      addr_sum;
    code_addr_t pc_inc;

    // Accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            a_q <= '0;
        end else if (ctrl.a_en) begin
            case (ctrl.a_sel)
                A_SEL_IMM: a_q <= k;
                A_SEL_ABS: a_q <= pkt_data;
                A_SEL_IND: a_q <= pkt_data;   // Same data path, address differs
                A_SEL_MEM: a_q <= scratch_rd;
                A_SEL_LEN: a_q <= pkt_len;
                A_SEL_ALU: a_q <= alu_result;
                A_SEL_X:   a_q <= x_q;        // TXA
            endcase
        end
    end

    // Index register
    always_ff @(posedge clk) begin
        if (rst) begin
            x_q <= '0;
        end else if (ctrl.x_en) begin
            case (ctrl.x_sel)
                X_SEL_IMM: x_q <= k;
                X_SEL_MEM: x_q <= scratch_rd;
                X_SEL_LEN: x_q <= pkt_len;
                X_SEL_MSH: x_q <= {26'b0, pkt_data[27:24], 2'b0}; // 4*(P[k]&0xf)
                X_SEL_A:   x_q <= a_q;        // TAX
                default:   x_q <= x_q;
            endcase
        end
    end

    // Offsets count from the next instruction
    assign pc_inc = pc_q + 1'b1;

    always_ff @(posedge clk) begin
        if (rst || ctrl.pc_clr) begin
            pc_q <= '0;
        end else if (ctrl.pc_en) begin
            case (ctrl.pc_sel)
                PC_PLUS_1:  pc_q <= pc_inc;
                PC_PLUS_JT: pc_q <= pc_inc + code_addr_t'(k[15:8]); // jt in k[15:8]
                PC_PLUS_JF: pc_q <= pc_inc + code_addr_t'(k[7:0]);  // jf in k[7:0]
                PC_PLUS_K:  pc_q <= pc_inc + code_addr_t'(k);
            endcase
        end
    end

    assign pc  = pc_q;
    assign acc = a_q;

    assign addr_sum = ctrl.addr_ind ? x_q + k : k;
    assign pkt_addr = byte_addr_t'(addr_sum);

    assign alu_b = ctrl.b_sel_x ? x_q : k;

    bpf_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .a      (a_q),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .en     (ctrl.alu_en),
        .ack    (ctrl.alu_ack),
        .result (alu_result),
        .flags  (flags),
        .vld    (alu_vld)
    );

    assign scratch_wr = ctrl.scratch_from_x ? x_q : a_q;

    scratch_mem u_scratch (
        .clk     (clk),
        .rst     (rst),
        .addr    (scratch_addr_t'(k)),
        .wr_data (scratch_wr),
        .wr_en   (ctrl.scratch_wr_en),
        .rd_data (scratch_rd)
    );

endmodule

//--- hw/bpf_controller.sv
`timescale 1ns/1ps

module bpf_controller (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    output logic                busy,
    output logic                done,
    output bpf_pkg::word_t      ret_val,
    output logic                inst_rd_en,
    input  bpf_pkg::inst_t      inst_data,
    output logic                pkt_rd_en,
    output bpf_pkg::dp_ctrl_t   ctrl,
    output bpf_pkg::word_t      k,
    input  bpf_pkg::alu_flags_t flags,
    input  logic                alu_vld,
    input  bpf_pkg::word_t      acc
);
    import bpf_pkg::*;

    ctrl_state_e state, state_d;
    inst_t       inst_q;
    word_t       ret_q;
    logic [15:0] op_k;

    // Decoded instruction
    a_sel_e  a_sel_d;
    x_sel_e  x_sel_d;
    alu_op_e alu_op_d;
    logic    wr_a_d, wr_x_d, wait_d, pkt_d, ind_d, st_d, st_x_d;
    logic    alu_d, cmp_d, ja_d, ret_d, taken_d;
    word_t   ret_val_d;

    assign op_k = inst_q.opcode & ~OP_SRC_X;

    always_comb begin
        a_sel_d   = A_SEL_IMM;
        x_sel_d   = X_SEL_IMM;
        alu_op_d  = ALU_SUB;   // Compares only look at the flags
        wr_a_d    = 1'b0;
        wr_x_d    = 1'b0;
        wait_d    = 1'b0;
        pkt_d     = 1'b0;
        ind_d     = 1'b0;
        st_d      = 1'b0;
        st_x_d    = 1'b0;
        alu_d     = 1'b0;
        cmp_d     = 1'b0;
        ja_d      = 1'b0;
        ret_d     = 1'b0;
        taken_d   = 1'b0;
        ret_val_d = '0;        // Unknown opcodes reject the packet
        case (inst_q.opcode)
            OP_LD_IMM:  begin wr_a_d = 1'b1; a_sel_d = A_SEL_IMM; end
            OP_LD_ABS:  begin wr_a_d = 1'b1; a_sel_d = A_SEL_ABS; wait_d = 1'b1; pkt_d = 1'b1; end
            OP_LD_IND:  begin
                wr_a_d  = 1'b1;
                a_sel_d = A_SEL_IND;
                wait_d  = 1'b1;
                pkt_d   = 1'b1;
                ind_d   = 1'b1;
            end
            OP_LD_MEM:  begin wr_a_d = 1'b1; a_sel_d = A_SEL_MEM; wait_d = 1'b1; end
            OP_LD_LEN:  begin wr_a_d = 1'b1; a_sel_d = A_SEL_LEN; end
            OP_LDX_IMM: begin wr_x_d = 1'b1; x_sel_d = X_SEL_IMM; end
            OP_LDX_MEM: begin wr_x_d = 1'b1; x_sel_d = X_SEL_MEM; wait_d = 1'b1; end
            OP_LDX_LEN: begin wr_x_d = 1'b1; x_sel_d = X_SEL_LEN; end
            OP_LDX_MSH: begin wr_x_d = 1'b1; x_sel_d = X_SEL_MSH; wait_d = 1'b1; pkt_d = 1'b1; end
            OP_ST:      st_d = 1'b1;
            OP_STX:     begin st_d = 1'b1; st_x_d = 1'b1; end
            OP_JA:      ja_d = 1'b1;
            OP_RET_K:   begin ret_d = 1'b1; ret_val_d = inst_q.k; end
            OP_RET_A:   begin ret_d = 1'b1; ret_val_d = acc; end
            OP_TAX:     begin wr_x_d = 1'b1; x_sel_d = X_SEL_A; end
            OP_TXA:     begin wr_a_d = 1'b1; a_sel_d = A_SEL_X; end
            default: begin
                a_sel_d = A_SEL_ALU;
                alu_d   = 1'b1;
                case (op_k)
                    OP_ALU_ADD: alu_op_d = ALU_ADD;
                    OP_ALU_SUB: alu_op_d = ALU_SUB;
                    OP_ALU_MUL: alu_op_d = ALU_MUL;
                    OP_ALU_OR:  alu_op_d = ALU_OR;
                    OP_ALU_AND: alu_op_d = ALU_AND;
                    OP_ALU_LSH: alu_op_d = ALU_LSH;
                    OP_ALU_RSH: alu_op_d = ALU_RSH;
                    OP_ALU_NEG: alu_op_d = ALU_NEG;
                    OP_ALU_XOR: alu_op_d = ALU_XOR;
                    OP_JEQ:     begin alu_d = 1'b0; cmp_d = 1'b1; taken_d = flags.eq; end
                    OP_JGT:     begin alu_d = 1'b0; cmp_d = 1'b1; taken_d = flags.gt; end
                    OP_JGE:     begin alu_d = 1'b0; cmp_d = 1'b1; taken_d = flags.ge; end
                    OP_JSET:    begin alu_d = 1'b0; cmp_d = 1'b1; taken_d = flags.set; end
                    default:    begin alu_d = 1'b0; ret_d = 1'b1; end
                endcase
            end
        endcase
    end

    always_comb begin
        state_d             = state;
        pkt_rd_en           = 1'b0;
        ctrl.a_sel          = a_sel_d;
        ctrl.a_en           = 1'b0;
        ctrl.x_sel          = x_sel_d;
        ctrl.x_en           = 1'b0;
        ctrl.pc_sel         = PC_PLUS_1;
        ctrl.pc_en          = 1'b0;
        ctrl.pc_clr         = 1'b0;
        ctrl.b_sel_x        = inst_q.opcode[3];
        ctrl.alu_op         = alu_op_d;
        ctrl.alu_en         = 1'b0;
        ctrl.alu_ack        = 1'b0;
        ctrl.scratch_from_x = st_x_d;
        ctrl.scratch_wr_en  = 1'b0;
        ctrl.addr_ind       = ind_d;
        case (state)
            S_IDLE:   if (start) state_d = S_FETCH;
            S_FETCH:  state_d = S_DECODE;
            S_DECODE: state_d = S_EXEC;
            S_EXEC: begin
                if (ret_d) begin
                    state_d = S_DONE;
                end else if (alu_d || cmp_d) begin
                    ctrl.alu_en = 1'b1;
                    state_d     = S_ALUWAIT;
                end else if (wait_d) begin
                    pkt_rd_en = pkt_d;   // Scratch reads need no strobe
                    state_d   = S_MEMWAIT;
                end else begin
                    ctrl.a_en          = wr_a_d;
                    ctrl.x_en          = wr_x_d;
                    ctrl.scratch_wr_en = st_d;
                    ctrl.pc_sel        = ja_d ? PC_PLUS_K : PC_PLUS_1;
                    ctrl.pc_en         = 1'b1;
                    state_d            = S_FETCH;
                end
            end
            S_MEMWAIT: begin
                ctrl.a_en  = wr_a_d;
                ctrl.x_en  = wr_x_d;
                ctrl.pc_en = 1'b1;
                state_d    = S_FETCH;
            end
            S_ALUWAIT: if (alu_vld) begin
                ctrl.alu_ack = 1'b1;
                ctrl.a_en    = alu_d;
                ctrl.pc_en   = 1'b1;
                if (cmp_d) ctrl.pc_sel = taken_d ? PC_PLUS_JT : PC_PLUS_JF;
                state_d = S_FETCH;
            end
            S_DONE: begin
                ctrl.pc_clr = 1'b1;
                state_d     = S_IDLE;
            end
            default:  state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= S_IDLE;
        else     state <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state == S_DECODE) inst_q <= inst_data;
        if (state == S_EXEC && ret_d) ret_q <= ret_val_d;
    end

    // Branch offsets ride on k during the resolve cycle
    assign k = (ctrl.pc_sel == PC_PLUS_JT || ctrl.pc_sel == PC_PLUS_JF) ?
               {16'h0, inst_q.jt, inst_q.jf} : inst_q.k;

    assign busy       = (state != S_IDLE);
    assign done       = (state == S_DONE);
    assign ret_val    = ret_q;
    assign inst_rd_en = (state == S_FETCH);

endmodule

//--- hw/bpf_cpu.sv
`timescale 1ns/1ps

module bpf_cpu (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  bpf_pkg::word_t      pkt_len,
    output logic                busy,
    output logic                done,
    output bpf_pkg::word_t      ret_val,
    output bpf_pkg::code_addr_t inst_addr,
    output logic                inst_rd_en,
    input  bpf_pkg::inst_t      inst_data,
    output bpf_pkg::byte_addr_t pkt_addr,
    output logic                pkt_rd_en,
    input  bpf_pkg::word_t      pkt_data
);
    import bpf_pkg::*;

    dp_ctrl_t   ctrl;
    word_t      k;
    word_t      acc;
    alu_flags_t flags;
    logic       alu_vld;

    bpf_controller u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .ret_val    (ret_val),
        .inst_rd_en (inst_rd_en),
        .inst_data  (inst_data),
        .pkt_rd_en  (pkt_rd_en),
        .ctrl       (ctrl),
        .k          (k),
        .flags      (flags),
        .alu_vld    (alu_vld),
        .acc        (acc)
    );

    datapath u_dp (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (ctrl),
        .k        (k),
        .pkt_len  (pkt_len),
        .pkt_data (pkt_data),
        .pc       (inst_addr),  // PC addresses the instruction memory directly
        .pkt_addr (pkt_addr),
        .acc      (acc),
        .flags    (flags),
        .alu_vld  (alu_vld)
    );

endmodule

//--- tb/bpf_cpu_assert.sv
`timescale 1ns/1ps

module bpf_cpu_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 start,
    input bpf_pkg::ctrl_state_e state,
    input logic                 done,
    input logic                 inst_rd_en,
    input logic                 pc_en,
    input logic                 alu_vld,
    input logic                 alu_ack
);
    import bpf_pkg::*;

    int fail_cnt = 0;

    // ALU result waits for the controller
    vld_hold: assert property (@(posedge clk) disable iff (rst)
        alu_vld && !alu_ack |=> alu_vld)
        else begin
            $error("ALU valid dropped before the acknowledge");
            fail_cnt++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            fail_cnt++;
        end

    // Fetch follows an accepted start or the PC step of the last instruction
    fetch_only: assert property (@(posedge clk) disable iff (rst)
        inst_rd_en |-> $past((state == S_IDLE && start) || pc_en))
        else begin
            $error("instruction read without an accepted start or a PC update before it");
            fail_cnt++;
        end

endmodule

// Controller ports see both sides of the ALU exchange
bind bpf_controller bpf_cpu_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .state      (state),
    .done       (done),
    .inst_rd_en (inst_rd_en),
    .pc_en      (ctrl.pc_en),
    .alu_vld    (alu_vld),
    .alu_ack    (ctrl.alu_ack)
);

//--- tb/bpf_cpu_tb.sv
`timescale 1ns/1ps

module bpf_cpu_tb;
    import bpf_pkg::*;

    localparam int PERIOD          = 40;
    localparam int NUM_PROGS       = 200;
    localparam int MAX_GROUPS      = 16;
    localparam int MAX_LEN         = 72;  // Scratch init, two words per group, final RET
    localparam int WATCHDOG_CYCLES = NUM_PROGS * MAX_LEN * 8 + 20;

    localparam logic [7:0][15:0] ALU_OPS = {OP_ALU_ADD, OP_ALU_SUB, OP_ALU_MUL, OP_ALU_OR,
                                            OP_ALU_AND, OP_ALU_LSH, OP_ALU_RSH, OP_ALU_XOR};
    localparam logic [3:0][15:0] CMP_OPS = {OP_JEQ, OP_JGT, OP_JGE, OP_JSET};

    logic       clk = 1'b0;
    logic       rst;
    logic       start;
    word_t      pkt_len;
    logic       busy;
    logic       done;
    word_t      ret_val;
    code_addr_t inst_addr;
    logic       inst_rd_en;
    inst_t      inst_data;
    byte_addr_t pkt_addr;
    logic       pkt_rd_en;
    word_t      pkt_data;

    integer     seed;
    inst_t      prog [MAX_LEN];
    int         grp_of [MAX_LEN];              // Group of each instruction
    int         gstart [MAX_GROUPS + 17];      // First instruction of each group
    logic [7:0] pkt [64];
    int         prog_len;
    int         ngrp;
    word_t      len_bytes;
    word_t      ma;                            // Reference A, X and scratch
    word_t      mx;
    word_t      mscr [16];
    int         done_cnt = 0;
    word_t      got_ret;

    always #(PERIOD / 2) clk = ~clk;

    bpf_cpu i_bpf_cpu (.*);

    function automatic word_t pkt_word(input int a);
        return {pkt[a], pkt[a + 1], pkt[a + 2], pkt[a + 3]}; // Big-endian
    endfunction

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Memories answer one cycle after the read strobe
    always @(posedge clk) begin
        if (inst_rd_en) inst_data <= #2 prog[inst_addr];
        if (pkt_rd_en)  pkt_data  <= #2 pkt_word(int'(pkt_addr));
    end

    always @(posedge clk) begin
        if (done) begin
            done_cnt <= done_cnt + 1;
            got_ret  <= ret_val;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic emit(input logic [15:0] op, input word_t k);
        prog[prog_len]   = {op, 16'h0000, k};
        grp_of[prog_len] = ngrp;
        prog_len++;
    endtask

    task automatic gen_group();
        int unsigned kind;
        int unsigned x0;
        logic [15:0] xbit;
        kind = rnd(16);
        xbit = (rnd(2) == 1) ? OP_SRC_X : 16'h0000;
        gstart[ngrp] = prog_len;
        case (kind)
            0: emit(OP_LD_IMM, $random(seed));
            1: emit(OP_LD_ABS, rnd(len_bytes - 3));
            2: begin
                x0 = rnd(len_bytes - 3);
                emit(OP_LDX_IMM, x0);            // X known, so X+k stays inside
                emit(OP_LD_IND, rnd(len_bytes - 3 - x0));
            end
            3: emit((rnd(2) == 1) ? OP_LD_LEN : OP_LDX_LEN, 0);
            4: emit(OP_LDX_IMM, $random(seed));
            5: emit((rnd(2) == 1) ? OP_LD_MEM : OP_LDX_MEM, rnd(16));
            6: emit(OP_LDX_MSH, rnd(len_bytes - 3));
            7: emit((rnd(2) == 1) ? OP_ST : OP_STX, rnd(16));
            8: emit((rnd(2) == 1) ? OP_TAX : OP_TXA, 0);
            9, 10, 11: emit(ALU_OPS[rnd(8)] | xbit, $random(seed));
            12: emit(OP_ALU_NEG, 0);
            13: emit(OP_JA, 0);                  // Offset patched later
            default: emit(CMP_OPS[rnd(4)] | xbit,
                          (rnd(2) == 1) ? word_t'($random(seed)) : rnd(4));
        endcase
        ngrp++;
    endtask

    task automatic gen_program(input int n);
        int g;
        int t;
        len_bytes = 16 + rnd(49);
        for (int i = 0; i < 64; i++) begin
            pkt[i] = 8'($random(seed));
        end
        prog_len = 0;
        ngrp     = 0;
        // First program fills every scratch word
        if (n == 0) begin
            for (int j = 0; j < 16; j++) begin
                gstart[ngrp] = prog_len;
                emit(OP_LD_IMM, $random(seed));
                emit(OP_ST, j);
                ngrp++;
            end
        end
        repeat (4 + rnd(MAX_GROUPS - 3)) gen_group();
        gstart[ngrp] = prog_len;
        emit(OP_RET_A, 0);
        // Jumps only land on the start of a later group
        for (int i = 0; i < prog_len; i++) begin
            if (prog[i].opcode[2:0] == 3'b101) begin
                g = grp_of[i];
                t = g + 1 + rnd(ngrp - g);
                if (prog[i].opcode == OP_JA) begin
                    prog[i].k = gstart[t] - (i + 1);
                end else begin
                    prog[i].jt = 8'(gstart[t] - (i + 1));
                    t = g + 1 + rnd(ngrp - g);
                    prog[i].jf = 8'(gstart[t] - (i + 1));
                end
            end
        end
    endtask

    task automatic run_model(output word_t r);
        int    pc;
        inst_t ins;
        word_t b;
        logic  fin;
        pc  = 0;
        fin = 1'b0;
        r   = '0;
        while (!fin) begin
            ins = prog[pc];
            b   = ins.opcode[3] ? mx : ins.k;
            pc  = pc + 1;                        // Offsets count from the next one
            case (ins.opcode & ~OP_SRC_X)
                OP_LD_IMM:  ma = ins.k;
                OP_LD_ABS:  ma = pkt_word(ins.k);
                OP_LD_IND:  ma = pkt_word(mx + ins.k);
                OP_LD_MEM:  ma = mscr[ins.k[3:0]];
                OP_LD_LEN:  ma = len_bytes;
                OP_LDX_IMM: mx = ins.k;
                OP_LDX_MEM: mx = mscr[ins.k[3:0]];
                OP_LDX_LEN: mx = len_bytes;
                OP_LDX_MSH: mx = 4 * word_t'(pkt[ins.k] & 8'h0f);
                OP_ST:      mscr[ins.k[3:0]] = ma;
                OP_STX:     mscr[ins.k[3:0]] = mx;
                OP_TAX:     mx = ma;
                OP_TXA:     ma = mx;
                OP_ALU_ADD: ma = ma + b;
                OP_ALU_SUB: ma = ma - b;
                OP_ALU_MUL: ma = ma * b;
                OP_ALU_OR:  ma = ma | b;
                OP_ALU_AND: ma = ma & b;
                OP_ALU_LSH: ma = ma << b[4:0];
                OP_ALU_RSH: ma = ma >> b[4:0];
                OP_ALU_XOR: ma = ma ^ b;
                OP_ALU_NEG: ma = -ma;
                OP_JA:      pc = pc + int'(ins.k);
                OP_JEQ:     pc = pc + ((ma == b) ? ins.jt : ins.jf);
                OP_JGT:     pc = pc + ((ma > b) ? ins.jt : ins.jf);
                OP_JGE:     pc = pc + ((ma >= b) ? ins.jt : ins.jf);
                OP_JSET:    pc = pc + (((ma & b) != 0) ? ins.jt : ins.jf);
                OP_RET_K: begin
                    r   = ins.k;
                    fin = 1'b1;
                end
                OP_RET_A: begin
                    r   = ma;
                    fin = 1'b1;
                end
                default:    fin = 1'b1;          // Unknown opcode returns zero
            endcase
        end
    endtask

    task automatic run_program(input word_t exp_ret);
        int cnt0;
        cnt0 = done_cnt;
        @(posedge clk);
        #2;
        start   = 1'b1;
        pkt_len = len_bytes;
        @(posedge clk);
        #2;
        start = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        assert (busy == 1'b1)
            else stop_on_error($sformatf("[ERROR] busy: got %h, expected 1", busy));
        start = 1'b1;                            // Extra start while busy
        @(posedge clk);
        #2;
        start = 1'b0;
        while (done_cnt == cnt0) @(posedge clk);
        #2;
        assert (busy == 1'b0)
            else stop_on_error($sformatf("[ERROR] busy after done: got %h, expected 0", busy));
        repeat (3) @(posedge clk);
        #2;
        assert (busy == 1'b0)
            else stop_on_error($sformatf("[ERROR] busy: got %h, expected 0", busy));
        assert (done_cnt == cnt0 + 1)
            else stop_on_error($sformatf("[ERROR] done pulse count: got %h, expected 1",
                                         done_cnt - cnt0));
        assert (got_ret == exp_ret)
            else stop_on_error($sformatf("[ERROR] ret_val: got %h, expected %h",
                                         got_ret, exp_ret));
        assert (i_bpf_cpu.u_ctrl.u_assert.fail_cnt == 0)
            else stop_on_error("A bound assertion failed while the program ran");
    endtask

    initial begin
        word_t exp_ret;
        seed      = 32'h88fa_fa17;
        rst       = 1'b1;
        start     = 1'b0;
        pkt_len   = '0;
        inst_data = '0;
        pkt_data  = '0;
        ma        = '0;
        mx        = '0;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        // Idle with no start
        repeat (5) begin
            @(posedge clk);
            #2;
            assert ({busy, done, inst_rd_en, pkt_rd_en} == 4'h0)
                else stop_on_error($sformatf(
                    "[ERROR] busy/done/inst_rd_en/pkt_rd_en: got %h, expected 0",
                    {busy, done, inst_rd_en, pkt_rd_en}));
        end
        for (int n = 0; n < NUM_PROGS; n++) begin
            gen_program(n);
            run_model(exp_ret);
            run_program(exp_ret);
        end
        if (i_bpf_cpu.u_ctrl.u_assert.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_on_error("Bound assertions reported failures");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        stop_on_error("Timeout: the DUT did not finish all programs in the expected time");
    end

endmodule

//--- verilog.f
+incdir+common
common/bpf_pkg.sv
datapath/scratch_mem.sv
datapath/bpf_alu.sv
datapath/datapath.sv
hw/bpf_controller.sv
hw/bpf_cpu.sv
tb/bpf_cpu_assert.sv
tb/bpf_cpu_tb.sv

//--- Bender.yml
package:
  name: bpf_cpu

sources:
  - include_dirs:
      - common
    files:
      - common/bpf_pkg.sv
      - datapath/scratch_mem.sv
      - datapath/bpf_alu.sv
      - datapath/datapath.sv
      - hw/bpf_controller.sv
      - hw/bpf_cpu.sv

  - target: test
    files:
      - tb/bpf_cpu_assert.sv
      - tb/bpf_cpu_tb.sv
